// File: design/br_pkg.sv
`default_nettype none

package br_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN      = 32;
    localparam int PHYS_REGS = 64;
    localparam int CDB_WIDTH = 2;
    localparam int RS_DEPTH  = 4;
    localparam int RS_IDX    = 2;

    typedef logic [XLEN-1:0]   word_t;
    // physical register 0 is hardwired to zero
    typedef logic [5:0]        phys_reg_t;
    typedef logic [4:0]        rob_id_t;
    typedef logic [RS_IDX-1:0] rs_idx_t;
    typedef logic [2:0]        br_op_t;

    //////////////////////////////////////////////////////////////////////
    // branch operation codes
    //////////////////////////////////////////////////////////////////////

    localparam br_op_t OP_BEQ  = 3'd0;
    localparam br_op_t OP_BNE  = 3'd1;
    localparam br_op_t OP_BLT  = 3'd2;
    localparam br_op_t OP_BGE  = 3'd3;
    localparam br_op_t OP_BLTU = 3'd4;
    localparam br_op_t OP_BGEU = 3'd5;
    localparam br_op_t OP_JAL  = 3'd6;
    localparam br_op_t OP_JALR = 3'd7;

    //////////////////////////////////////////////////////////////////////
    // records
    //////////////////////////////////////////////////////////////////////

    // renamed micro-op as it leaves dispatch
    typedef struct packed {
        rob_id_t   rob_id;
        br_op_t    op;
        phys_reg_t rs1_phy;
        logic      rs1_valid;
        phys_reg_t rs2_phy;
        logic      rs2_valid;
        phys_reg_t rd_phy;
        logic      rd_write;
        word_t     pc;
        word_t     imm;
        logic      predict_taken;
        word_t     predict_target;
    } br_uop_t;

    // one result broadcast
    typedef struct packed {
        logic      valid;
        phys_reg_t rd_phy;
        word_t     value;
    } cdb_t;

    // station to branch unit, operands already read
    typedef struct packed {
        rob_id_t   rob_id;
        br_op_t    op;
        phys_reg_t rs1_phy;
        phys_reg_t rs2_phy;
        phys_reg_t rd_phy;
        logic      rd_write;
        word_t     pc;
        word_t     imm;
        logic      predict_taken;
        word_t     predict_target;
        word_t     rs1_value;
        word_t     rs2_value;
    } br_issue_t;

    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
        logic    taken;
        word_t   target;
        logic    mispredict;
    } br_result_t;

endpackage

`default_nettype wire

// File: design/br_rs.sv
`timescale 1ns/1ps
`default_nettype none

module br_rs (
    input  logic               clk,
    input  logic               rst,

    input  logic               dispatch_valid,
    input  br_pkg::br_uop_t    dispatch_uop,
    output logic               dispatch_ready,

    input  br_pkg::cdb_t       cdb_in [br_pkg::CDB_WIDTH],

    output br_pkg::phys_reg_t  rs1_phy,
    output br_pkg::phys_reg_t  rs2_phy,
    input  br_pkg::word_t      rs1_value,
    input  br_pkg::word_t      rs2_value,

    output logic               issue_valid,
    output br_pkg::br_issue_t  issue
);

    //////////////////////////////////////////////////////////////////////
    // entry storage
    //////////////////////////////////////////////////////////////////////

    br_pkg::br_uop_t                rs_entry [br_pkg::RS_DEPTH];
    logic [br_pkg::RS_DEPTH-1:0]    occupied;

    logic                           alloc_en;
    br_pkg::rs_idx_t                alloc_idx;
    br_pkg::rs_idx_t                issue_idx;

    // source matches any valid broadcast this cycle
    function automatic logic cdb_hit(br_pkg::phys_reg_t phy,
                                     br_pkg::cdb_t      bus [br_pkg::CDB_WIDTH]);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < br_pkg::CDB_WIDTH; k++) begin
            if (bus[k].valid && (bus[k].rd_phy == phy)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // allocation
    //////////////////////////////////////////////////////////////////////

    // ready only looks at current occupancy
    assign dispatch_ready = ~(&occupied);
    assign alloc_en       = dispatch_valid && dispatch_ready;

    // lowest free entry
    always_comb begin
        alloc_idx = '0;
        for (int i = br_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                alloc_idx = br_pkg::rs_idx_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // select
    //////////////////////////////////////////////////////////////////////

    // lowest occupied entry with both sources ready, stored or woken now
    always_comb begin
        logic found;
        logic src1_ok;
        logic src2_ok;
        found     = 1'b0;
        issue_idx = '0;
        for (int i = 0; i < br_pkg::RS_DEPTH; i++) begin
            src1_ok = rs_entry[i].rs1_valid || cdb_hit(rs_entry[i].rs1_phy, cdb_in);
            src2_ok = rs_entry[i].rs2_valid || cdb_hit(rs_entry[i].rs2_phy, cdb_in);
            if (!found && occupied[i] && src1_ok && src2_ok) begin
                found     = 1'b1;
                issue_idx = br_pkg::rs_idx_t'(i);
            end
        end
        issue_valid = found;
    end

    //////////////////////////////////////////////////////////////////////
    // entry update
    //////////////////////////////////////////////////////////////////////

    // occupancy is the only control state
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
        end else begin
            if (alloc_en) begin
                occupied[alloc_idx] <= 1'b1;
            end
            // never the alloc entry, that one was free
            if (issue_valid) begin
                occupied[issue_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wakeup of waiting entries
        for (int i = 0; i < br_pkg::RS_DEPTH; i++) begin
            if (occupied[i]) begin
                if (cdb_hit(rs_entry[i].rs1_phy, cdb_in)) begin
                    rs_entry[i].rs1_valid <= 1'b1;
                end
                if (cdb_hit(rs_entry[i].rs2_phy, cdb_in)) begin
                    rs_entry[i].rs2_valid <= 1'b1;
                end
            end
        end
        // new uop also catches a broadcast landing on its dispatch edge
        if (alloc_en) begin
            rs_entry[alloc_idx] <= dispatch_uop;
            rs_entry[alloc_idx].rs1_valid <= dispatch_uop.rs1_valid ||
                                             cdb_hit(dispatch_uop.rs1_phy, cdb_in);
            rs_entry[alloc_idx].rs2_valid <= dispatch_uop.rs2_valid ||
                                             cdb_hit(dispatch_uop.rs2_phy, cdb_in);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register read and issue record
    //////////////////////////////////////////////////////////////////////

    assign rs1_phy = rs_entry[issue_idx].rs1_phy;
    assign rs2_phy = rs_entry[issue_idx].rs2_phy;

    always_comb begin
        issue.rob_id         = rs_entry[issue_idx].rob_id;
        issue.op             = rs_entry[issue_idx].op;
        issue.rs1_phy        = rs_entry[issue_idx].rs1_phy;
        issue.rs2_phy        = rs_entry[issue_idx].rs2_phy;
        issue.rd_phy         = rs_entry[issue_idx].rd_phy;
        issue.rd_write       = rs_entry[issue_idx].rd_write;
        issue.pc             = rs_entry[issue_idx].pc;
        issue.imm            = rs_entry[issue_idx].imm;
        issue.predict_taken  = rs_entry[issue_idx].predict_taken;
        issue.predict_target = rs_entry[issue_idx].predict_target;
        // operands straight from the register file, bypass included
        issue.rs1_value      = rs1_value;
        issue.rs2_value      = rs2_value;
    end

endmodule

`default_nettype wire

// File: design/prf_bank.sv
`timescale 1ns/1ps
`default_nettype none

module prf_bank (
    input  logic               clk,
    input  logic               rst,

    input  br_pkg::cdb_t       cdb_in [br_pkg::CDB_WIDTH],

    input  br_pkg::phys_reg_t  rs1_phy,
    input  br_pkg::phys_reg_t  rs2_phy,
    output br_pkg::word_t      rs1_value,
    output br_pkg::word_t      rs2_value
);

    br_pkg::word_t regs [br_pkg::PHYS_REGS];

    //////////////////////////////////////////////////////////////////////
    // write ports
    //////////////////////////////////////////////////////////////////////

    // higher port wins on a same-register collision
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < br_pkg::PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < br_pkg::CDB_WIDTH; k++) begin
                if (cdb_in[k].valid && (cdb_in[k].rd_phy != '0)) begin
                    regs[cdb_in[k].rd_phy] <= cdb_in[k].value;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports with write bypass
    //////////////////////////////////////////////////////////////////////

    function automatic br_pkg::word_t read_port(
        br_pkg::phys_reg_t phy,
        br_pkg::word_t     file [br_pkg::PHYS_REGS],
        br_pkg::cdb_t      bus  [br_pkg::CDB_WIDTH]
    );
        br_pkg::word_t value;
        value = file[phy];
        // same order as the write loop so bypass matches the stored value
        for (int k = 0; k < br_pkg::CDB_WIDTH; k++) begin
            if (bus[k].valid && (bus[k].rd_phy == phy) && (phy != '0)) begin
                value = bus[k].value;
            end
        end
        return value;
    endfunction

    always_comb begin
        rs1_value = read_port(rs1_phy, regs, cdb_in);
        rs2_value = read_port(rs2_phy, regs, cdb_in);
    end

endmodule

`default_nettype wire

// File: design/fu_br.sv
`timescale 1ns/1ps
`default_nettype none

module fu_br (
    input  logic               clk,
    input  logic               rst,

    input  logic               issue_valid,
    input  br_pkg::br_issue_t  issue,

    output br_pkg::cdb_t       br_cdb,
    output br_pkg::br_result_t br_result
);

    //////////////////////////////////////////////////////////////////////
    // resolve
    //////////////////////////////////////////////////////////////////////

    logic          taken;
    br_pkg::word_t target;
    br_pkg::word_t link;
    logic          mispredict;

    // direction
    always_comb begin
        unique case (issue.op)
            br_pkg::OP_BEQ:  taken = (issue.rs1_value == issue.rs2_value);
            br_pkg::OP_BNE:  taken = (issue.rs1_value != issue.rs2_value);
            br_pkg::OP_BLT:  taken = ($signed(issue.rs1_value) <  $signed(issue.rs2_value));
            br_pkg::OP_BGE:  taken = ($signed(issue.rs1_value) >= $signed(issue.rs2_value));
            br_pkg::OP_BLTU: taken = (issue.rs1_value <  issue.rs2_value);
            br_pkg::OP_BGEU: taken = (issue.rs1_value >= issue.rs2_value);
            br_pkg::OP_JAL:  taken = 1'b1;
            br_pkg::OP_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // target, jalr is register relative with bit 0 forced low
    always_comb begin
        if (issue.op == br_pkg::OP_JALR) begin
            target = (issue.rs1_value + issue.imm) & ~br_pkg::word_t'(1);
        end else begin
            target = issue.pc + issue.imm;
        end
    end

    assign link = issue.pc + br_pkg::word_t'(4);

    // wrong direction, or right direction to the wrong place
    assign mispredict = (taken != issue.predict_taken) ||
                        (taken && (target != issue.predict_target));

    //////////////////////////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            br_result.valid <= 1'b0;
            br_cdb.valid    <= 1'b0;
        end else begin
            br_result.valid <= issue_valid;
            // link write only for ops that name a destination
            br_cdb.valid    <= issue_valid && issue.rd_write;
        end
    end

    always_ff @(posedge clk) begin
        br_result.rob_id     <= issue.rob_id;
        br_result.taken      <= taken;
        br_result.target     <= target;
        br_result.mispredict <= mispredict;
        br_cdb.rd_phy        <= issue.rd_phy;
        br_cdb.value         <= link;
    end

endmodule

`default_nettype wire

// File: design/br_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module br_exec_top (
    input  logic               clk,
    input  logic               rst,

    input  logic               dispatch_valid,
    input  br_pkg::br_uop_t    dispatch_uop,
    output logic               dispatch_ready,

    input  br_pkg::cdb_t       cdb_in [br_pkg::CDB_WIDTH],

    output br_pkg::cdb_t       br_cdb,
    output br_pkg::br_result_t br_result
);

    //////////////////////////////////////////////////////////////////////
    // station, register file and branch unit
    //////////////////////////////////////////////////////////////////////

    br_pkg::phys_reg_t  rs1_phy;
    br_pkg::phys_reg_t  rs2_phy;
    br_pkg::word_t      rs1_value;
    br_pkg::word_t      rs2_value;
    logic               issue_valid;
    br_pkg::br_issue_t  issue;

    br_rs u_br_rs (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb_in         (cdb_in),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    // the same external broadcasts feed wakeup and register writes
    prf_bank u_prf_bank (
        .clk       (clk),
        .rst       (rst),
        .cdb_in    (cdb_in),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_br u_fu_br (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .br_cdb      (br_cdb),
        .br_result   (br_result)
    );

endmodule

`default_nettype wire

// File: dv/br_exec_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module br_exec_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         dispatch_ready,
    input logic                         issue_valid,
    input br_pkg::rs_idx_t              issue_idx,
    input logic [br_pkg::RS_DEPTH-1:0]  occupied
);

    // station leaves reset empty
    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !issue_valid)
        else $error("issue_valid high in the cycle after reset");

    // while full occupancy only drops by the entry that issued
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        !dispatch_ready |=>
            ($countones(occupied) == br_pkg::RS_DEPTH - int'($past(issue_valid))))
        else $error("entry allocated while dispatch_ready was low");

    // an issued entry reads free afterwards, so it cannot issue a second time
    a_issue_frees_entry: assert property (@(posedge clk) disable iff (rst)
        issue_valid |=> !occupied[$past(issue_idx)])
        else $error("issued entry still occupied after issue");

endmodule

bind br_rs br_exec_assertions u_br_exec_assertions (
    .clk            (clk),
    .rst            (rst),
    .dispatch_ready (dispatch_ready),
    .issue_valid    (issue_valid),
    .issue_idx      (issue_idx),
    .occupied       (occupied)
);

`default_nettype wire

// File: dv/br_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module br_exec_tb;

    logic                clk = 1'b0;
    logic                rst;
    logic                dispatch_valid;
    br_pkg::br_uop_t     dispatch_uop;
    logic                dispatch_ready;
    br_pkg::cdb_t        cdb_in [br_pkg::CDB_WIDTH];
    br_pkg::cdb_t        br_cdb;
    br_pkg::br_result_t  br_result;

    // scoreboard by rob id
    // sent and seen counts have one writer each
    br_pkg::br_result_t  exp_result [32];
    logic                exp_link_valid [32];
    br_pkg::phys_reg_t   exp_link_rd [32];
    br_pkg::word_t       exp_link [32];
    logic                armed [32];
    int                  accept_cycle [32];
    int                  sent_seq [32];
    int                  seen_seq [32];

    br_pkg::word_t       reg_model [br_pkg::PHYS_REGS];
    br_pkg::word_t       rand_state = 32'd74769;
    int                  cycle = 0;

    br_exec_top dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .cdb_in         (cdb_in),
        .br_cdb         (br_cdb),
        .br_result      (br_result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic br_pkg::word_t next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic br_pkg::br_result_t resolve_branch(br_pkg::br_uop_t u,
                                                          br_pkg::word_t a,
                                                          br_pkg::word_t b);
        br_pkg::br_result_t r;
        br_pkg::word_t      sa;
        br_pkg::word_t      sb;
        br_pkg::word_t      sum;
        // flipping the sign bit turns signed order into unsigned order
        sa = a ^ 32'h8000_0000;
        sb = b ^ 32'h8000_0000;
        r.valid  = 1'b1;
        r.rob_id = u.rob_id;
        case (u.op)
            br_pkg::OP_BEQ:  r.taken = (a == b);
            br_pkg::OP_BNE:  r.taken = (a != b);
            br_pkg::OP_BLT:  r.taken = (sa < sb);
            br_pkg::OP_BGE:  r.taken = !(sa < sb);
            br_pkg::OP_BLTU: r.taken = (a < b);
            br_pkg::OP_BGEU: r.taken = !(a < b);
            default:         r.taken = 1'b1;
        endcase
        sum = a + u.imm;
        if (u.op == br_pkg::OP_JALR) begin
            r.target = {sum[31:1], 1'b0};
        end else begin
            r.target = u.pc + u.imm;
        end
        // a taken branch is only predicted right with the right target
        if (r.taken) begin
            r.mispredict = !(u.predict_taken && (r.target == u.predict_target));
        end else begin
            r.mispredict = u.predict_taken;
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input br_pkg::word_t got,
                            input br_pkg::word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR: %0t ns: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_broadcast(input logic port, input br_pkg::phys_reg_t r,
                                   input br_pkg::word_t v);
        cdb_in[port].valid  = 1'b1;
        cdb_in[port].rd_phy = r;
        cdb_in[port].value  = v;
        if (r != '0) begin
            reg_model[r] = v;
        end
    endtask

    task automatic clear_broadcast();
        for (int p = 0; p < br_pkg::CDB_WIDTH; p++) begin
            cdb_in[p] = '0;
        end
    endtask

    task automatic broadcast_reg(input logic port, input br_pkg::phys_reg_t r,
                                 input br_pkg::word_t v);
        drive_broadcast(port, r, v);
        next_cycle();
        clear_broadcast();
    endtask

    // builds a uop
    // a and b are the source values it must resolve with
    task automatic plan_uop(input br_pkg::rob_id_t rob, input br_pkg::br_op_t op,
                            input br_pkg::phys_reg_t s1, input logic v1,
                            input br_pkg::phys_reg_t s2, input logic v2,
                            input br_pkg::word_t a, input br_pkg::word_t b,
                            input logic rd_write, input logic wrong,
                            output br_pkg::br_uop_t u);
        br_pkg::br_result_t r;
        br_pkg::word_t      noise;
        noise       = next_rand();
        u           = '0;
        u.rob_id    = rob;
        u.op        = op;
        u.rs1_phy   = s1;
        u.rs1_valid = v1;
        u.rs2_phy   = s2;
        u.rs2_valid = v2;
        u.rd_phy    = br_pkg::phys_reg_t'(rob) + 6'd32;
        u.rd_write  = rd_write;
        u.pc        = {noise[31:2], 2'b00};
        noise       = next_rand();
        // odd jalr offsets exercise the bit 0 clear
        u.imm       = {{20{noise[11]}}, noise[11:1], (op == br_pkg::OP_JALR)};
        r = resolve_branch(u, a, b);
        u.predict_taken  = r.taken;
        u.predict_target = r.target;
        if (wrong) begin
            noise = next_rand();
            if (noise[4] || !r.taken) begin
                u.predict_taken = !r.taken;
            end else begin
                u.predict_target = r.target + 32'd16;
            end
        end
        exp_result[rob]     = resolve_branch(u, a, b);
        exp_link_valid[rob] = rd_write;
        exp_link_rd[rob]    = u.rd_phy;
        exp_link[rob]       = u.pc + 32'd4;
        armed[rob]          = v1 && v2;
        sent_seq[rob]       = sent_seq[rob] + 1;
    endtask

    task automatic send_uop(input br_pkg::br_uop_t u);
        logic accepted;
        accepted       = 1'b0;
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        while (!accepted) begin
            @(negedge clk);
            if (dispatch_ready) begin
                accepted = 1'b1;
                accept_cycle[u.rob_id] = cycle;
            end
            next_cycle();
        end
        dispatch_valid = 1'b0;
    endtask

    function automatic int open_count();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += sent_seq[i] - seen_seq[i];
        end
        return n;
    endfunction

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (open_count() != 0 && waited < 100) begin
            next_cycle();
            waited++;
        end
        // a stray result would show here
        repeat (2) next_cycle();
    endtask

    //////////////////////////////////////////////////////////////////////
    // result monitor
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        br_pkg::rob_id_t rob;
        rob = br_result.rob_id;
        if (!rst && br_cdb.valid && !br_result.valid) begin
            stop_with_failure("link broadcast seen without a branch result");
        end
        if (!rst && br_result.valid) begin
            if (sent_seq[rob] == seen_seq[rob]) begin
                stop_with_failure($sformatf("result for rob %0d that is not outstanding", rob));
            end
            if (!armed[rob]) begin
                stop_with_failure($sformatf("rob %0d resolved before its sources arrived", rob));
            end
            if (cycle - accept_cycle[rob] < 2) begin
                stop_with_failure($sformatf("rob %0d resolved too soon after dispatch", rob));
            end
            check_eq("taken", br_pkg::word_t'(br_result.taken),
                     br_pkg::word_t'(exp_result[rob].taken));
            check_eq("target", br_result.target, exp_result[rob].target);
            check_eq("mispredict", br_pkg::word_t'(br_result.mispredict),
                     br_pkg::word_t'(exp_result[rob].mispredict));
            check_eq("link valid", br_pkg::word_t'(br_cdb.valid),
                     br_pkg::word_t'(exp_link_valid[rob]));
            if (exp_link_valid[rob]) begin
                check_eq("link rd", br_pkg::word_t'(br_cdb.rd_phy),
                         br_pkg::word_t'(exp_link_rd[rob]));
                check_eq("link value", br_cdb.value, exp_link[rob]);
            end
            seen_seq[rob] = seen_seq[rob] + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic ready_operand_ops();
        br_pkg::br_uop_t   u;
        br_pkg::phys_reg_t s1;
        br_pkg::phys_reg_t s2;
        for (int r = 1; r <= 8; r++) begin
            broadcast_reg(r[0], br_pkg::phys_reg_t'(r), next_rand());
        end
        // each opcode once predicted right, once wrong
        for (int k = 0; k < 16; k++) begin
            s1 = br_pkg::phys_reg_t'(1 + k % 8);
            s2 = (k % 4 == 0) ? s1 : br_pkg::phys_reg_t'(1 + (k + 3) % 8);
            plan_uop(br_pkg::rob_id_t'(k), br_pkg::br_op_t'(k % 8), s1, 1'b1, s2, 1'b1,
                     reg_model[s1], reg_model[s2], k[0] ^ k[3], k[3], u);
            send_uop(u);
        end
        wait_drain();
    endtask

    task automatic wakeup_order();
        br_pkg::br_uop_t u;
        br_pkg::word_t   v [6];
        for (int i = 0; i < 6; i++) begin
            v[i] = next_rand();
        end
        plan_uop(5'd0, br_pkg::OP_BLT, 6'd10, 1'b0, 6'd11, 1'b0, v[0], v[1], 1'b1, 1'b0, u);
        send_uop(u);
        plan_uop(5'd1, br_pkg::OP_BGEU, 6'd12, 1'b0, 6'd13, 1'b0, v[2], v[3], 1'b0, 1'b1, u);
        send_uop(u);
        plan_uop(5'd2, br_pkg::OP_JALR, 6'd14, 1'b0, 6'd10, 1'b0, v[4], v[0], 1'b1, 1'b0, u);
        send_uop(u);
        repeat (6) next_cycle();
        broadcast_reg(1'b0, 6'd13, v[3]);
        broadcast_reg(1'b1, 6'd11, v[1]);
        armed[1] = 1'b1;
        broadcast_reg(1'b0, 6'd12, v[2]);
        // both remaining ops wake in the same cycle
        armed[0] = 1'b1;
        armed[2] = 1'b1;
        drive_broadcast(1'b0, 6'd14, v[4]);
        drive_broadcast(1'b1, 6'd10, v[0]);
        next_cycle();
        clear_broadcast();
        wait_drain();
    endtask

    task automatic same_cycle_bypass();
        br_pkg::br_uop_t u;
        br_pkg::word_t   old_val;
        br_pkg::word_t   new_val;
        br_pkg::word_t   base;
        old_val = next_rand();
        new_val = old_val ^ 32'h0000_0f00;
        base    = next_rand();
        broadcast_reg(1'b0, 6'd20, old_val);
        broadcast_reg(1'b1, 6'd21, new_val);
        broadcast_reg(1'b0, 6'd23, old_val);
        // taken only if the new value reaches the unit
        plan_uop(5'd3, br_pkg::OP_BEQ, 6'd20, 1'b0, 6'd21, 1'b1, new_val, new_val,
                 1'b0, 1'b0, u);
        send_uop(u);
        armed[3] = 1'b1;
        broadcast_reg(1'b0, 6'd20, new_val);
        plan_uop(5'd4, br_pkg::OP_JALR, 6'd23, 1'b0, 6'd0, 1'b1, base, 32'd0, 1'b1, 1'b0, u);
        send_uop(u);
        armed[4] = 1'b1;
        broadcast_reg(1'b1, 6'd23, base);
        wait_drain();
    endtask

    task automatic full_station();
        br_pkg::br_uop_t u;
        br_pkg::word_t   v [5];
        int              wake_cycle;
        for (int i = 0; i < 5; i++) begin
            v[i] = next_rand();
        end
        for (int i = 0; i < br_pkg::RS_DEPTH; i++) begin
            plan_uop(br_pkg::rob_id_t'(8 + i), br_pkg::br_op_t'(i), br_pkg::phys_reg_t'(30 + i),
                     1'b0, 6'd1, 1'b1, v[i], reg_model[1], i[0], i[1], u);
            send_uop(u);
        end
        @(negedge clk);
        check_eq("dispatch_ready when full", br_pkg::word_t'(dispatch_ready), 32'd0);
        next_cycle();
        plan_uop(5'd12, br_pkg::OP_BNE, 6'd34, 1'b0, 6'd2, 1'b1, v[4], reg_model[2],
                 1'b1, 1'b0, u);
        wake_cycle = 0;
        fork
            send_uop(u);
            begin
                repeat (5) begin
                    @(negedge clk);
                    check_eq("dispatch_ready while held", br_pkg::word_t'(dispatch_ready),
                             32'd0);
                    next_cycle();
                end
                // frees entry 1 for the held uop
                wake_cycle = cycle;
                armed[9]   = 1'b1;
                broadcast_reg(1'b0, 6'd31, v[1]);
            end
        join
        check_eq("accept cycle of held uop", br_pkg::word_t'(accept_cycle[12]),
                 br_pkg::word_t'(wake_cycle + 1));
        @(negedge clk);
        check_eq("dispatch_ready after refill", br_pkg::word_t'(dispatch_ready), 32'd0);
        next_cycle();
        armed[8]  = 1'b1;
        armed[10] = 1'b1;
        drive_broadcast(1'b0, 6'd30, v[0]);
        drive_broadcast(1'b1, 6'd32, v[2]);
        next_cycle();
        armed[11] = 1'b1;
        armed[12] = 1'b1;
        drive_broadcast(1'b0, 6'd33, v[3]);
        drive_broadcast(1'b1, 6'd34, v[4]);
        next_cycle();
        clear_broadcast();
        wait_drain();
    endtask

    task automatic zero_reg_jalr();
        br_pkg::br_uop_t u;
        br_pkg::word_t   junk;
        junk = next_rand() | 32'h1;
        broadcast_reg(1'b0, 6'd0, junk);
        plan_uop(5'd13, br_pkg::OP_JALR, 6'd0, 1'b1, 6'd0, 1'b1, 32'd0, 32'd0,
                 1'b1, 1'b0, u);
        send_uop(u);
        // register 0 write in the issue cycle is never bypassed
        broadcast_reg(1'b1, 6'd0, junk);
        plan_uop(5'd14, br_pkg::OP_JALR, 6'd5, 1'b1, 6'd0, 1'b1, reg_model[5], 32'd0,
                 1'b0, 1'b1, u);
        send_uop(u);
        wait_drain();
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        clear_broadcast();
        for (int i = 0; i < 32; i++) begin
            armed[i]        = 1'b0;
            accept_cycle[i] = 0;
            sent_seq[i]     = 0;
            seen_seq[i]     = 0;
        end
        for (int i = 0; i < br_pkg::PHYS_REGS; i++) begin
            reg_model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_eq("dispatch_ready after reset", br_pkg::word_t'(dispatch_ready), 32'd1);
        check_eq("br_result.valid after reset", br_pkg::word_t'(br_result.valid), 32'd0);
        check_eq("br_cdb.valid after reset", br_pkg::word_t'(br_cdb.valid), 32'd0);
        next_cycle();
        ready_operand_ops();
        wakeup_order();
        same_cycle_bypass();
        full_station();
        zero_reg_jalr();
        if (open_count() != 0) begin
            stop_with_failure($sformatf("%0d branches never resolved", open_count()));
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial begin : watchdog
        int limit;
        // reset plus 200 cycles for each of the five tests
        limit = 10 + 5 * 200;
        repeat (limit) @(posedge clk);
        stop_with_failure("timeout, the tests did not finish in the cycle budget");
    end

endmodule

`default_nettype wire

// File: verilog.f
design/br_pkg.sv
design/br_rs.sv
design/prf_bank.sv
design/fu_br.sv
design/br_exec_top.sv
dv/br_exec_assertions.sv
dv/br_exec_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := br_exec_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
